//--- common/rtcDisplay_settings.svh
`ifndef RTCDISPLAY_SETTINGS_SVH
`define RTCDISPLAY_SETTINGS_SVH

//////////////////// VGA 640x480 timing
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

//////////////////// Text block placement
`define TEXT_X0 64 // Top-left pixel of cell 0
`define TEXT_Y0 64
`define FONT_SCALE 4 // Each font pixel is 4x4 screen pixels
`define CELL_PIX 32 // 8 font pixels times scale

// 12-bit RGB, 4 bits per channel
`define FG_COLOR 12'hFFE
`define BG_COLOR 12'h032
`define BLANK_COLOR 12'h000

//////////////////// RTC fields
`define RTC_W 8
`define NUM_FIELDS 11
`define CLOCK_FIELDS 8 // Timer fields follow these

`endif

//--- common/rtcDisplay_pkg.sv
package rtcDisplay_pkg;

    // Capture order on the RTC bus
    typedef enum logic [3:0] {
        secs,
        mins,
        hours,
        date,
        month,
        year,
        weekday,
        weekNum,
        tSecs, // Timer fields, only with timerOn
        tMins,
        tHours
    } fieldIdx;

    typedef enum logic [1:0] {
        idle,
        collect,
        commit,
        abort
    } captureState;

    typedef logic [6:0] asciiChar;

    localparam asciiChar charSpace = 7'h20;
    localparam asciiChar charDash = 7'h2D;
    localparam asciiChar charSlash = 7'h2F;
    localparam asciiChar charZero = 7'h30;
    localparam asciiChar charColon = 7'h3A;

    //////////////////// 8x8 font
    // Top row in the upper byte, bit 7 is the leftmost pixel
    function automatic logic [7:0] glyphRow(input asciiChar ch, input logic [2:0] row);
        logic [63:0] glyph;
        case (ch)
            7'h30: glyph = 64'h3C66_6E76_6666_3C00; // 0
            7'h31: glyph = 64'h1838_1818_1818_7E00;
            7'h32: glyph = 64'h3C66_060C_1830_7E00;
            7'h33: glyph = 64'h3C66_061C_0666_3C00;
            7'h34: glyph = 64'h0C1C_3C6C_7E0C_0C00;
            7'h35: glyph = 64'h7E60_7C06_0666_3C00;
            7'h36: glyph = 64'h1C30_607C_6666_3C00;
            7'h37: glyph = 64'h7E06_0C18_3030_3000;
            7'h38: glyph = 64'h3C66_663C_6666_3C00;
            7'h39: glyph = 64'h3C66_663E_060C_3800; // 9
            7'h3A: glyph = 64'h0018_1800_1818_0000; // Colon
            7'h2F: glyph = 64'h0206_0C18_3060_4000; // Slash
            7'h2D: glyph = 64'h0000_007E_0000_0000; // Dash
            default: glyph = 64'h0; // Space and unknown codes
        endcase
        return glyph[8 * (3'd7 - row) +: 8];
    endfunction

endpackage

//--- rtl/vgaTiming.sv
`include "rtcDisplay_settings.svh"

module vgaTiming (
    input  logic       clk,
    input  logic       rstN,
    output logic [9:0] pixelX,
    output logic [9:0] pixelY,
    output logic       hsyncRaw,
    output logic       vsyncRaw,
    output logic       activeRaw
);

    localparam int hTotal = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK; // 800
    localparam int vTotal = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK; // 525
    localparam int hSyncStart = `H_ACTIVE + `H_FRONT; // 656
    localparam int hSyncEnd = hSyncStart + `H_SYNC; // First pixel after the pulse
    localparam int vSyncStart = `V_ACTIVE + `V_FRONT; // 490
    localparam int vSyncEnd = vSyncStart + `V_SYNC;

    logic [9:0] nextX;
    logic [9:0] nextY;
    logic       lineEnd;

    assign lineEnd = (pixelX == 10'(hTotal - 1));

    always_comb begin
        nextX = lineEnd ? 10'd0 : pixelX + 10'd1;
        nextY = pixelY;
        if (lineEnd) begin
            nextY = (pixelY == 10'(vTotal - 1)) ? 10'd0 : pixelY + 10'd1; // Frame wrap
        end
    end

    // Flags decoded from the next position, so they line up with the counters
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixelX    <= 10'd0;
            pixelY    <= 10'd0;
            hsyncRaw  <= 1'b1;
            vsyncRaw  <= 1'b1;
            activeRaw <= 1'b1; // Pixel (0,0) is visible
        end else begin
            pixelX    <= nextX;
            pixelY    <= nextY;
            hsyncRaw  <= !((nextX >= 10'(hSyncStart)) && (nextX < 10'(hSyncEnd))); // Active low
            vsyncRaw  <= !((nextY >= 10'(vSyncStart)) && (nextY < 10'(vSyncEnd)));
            activeRaw <= (nextX < 10'(`H_ACTIVE)) && (nextY < 10'(`V_ACTIVE));
        end
    end

endmodule

//--- capture/fieldCapture.sv
`include "rtcDisplay_settings.svh"

module fieldCapture (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     seqStart,
    input  logic                     timerOn,
    input  logic [`RTC_W-1:0]        rtcData,
    input  logic [9:0]               pixelX,
    input  logic [9:0]               pixelY,
    output logic                     wrEn,
    output logic                     commit,
    output logic                     timerLatched,
    output rtcDisplay_pkg::fieldIdx  wrField,
    output rtcDisplay_pkg::asciiChar wrTens,
    output rtcDisplay_pkg::asciiChar wrUnits
);
    import rtcDisplay_pkg::*;

    captureState state;
    captureState stateNext;
    fieldIdx     curField;
    fieldIdx     lastField;
    asciiChar    tensChar;
    asciiChar    unitsChar;
    logic        windowStart;
    logic        frameWrap;
    logic        sampleNow;

    assign windowStart = (pixelY == 10'(`V_ACTIVE)) && (pixelX == 10'd0); // First blank line
    assign frameWrap = (pixelY == 10'd0);
    assign sampleNow = (state == collect) && seqStart && !frameWrap;
    assign lastField = timerLatched ? fieldIdx'(`NUM_FIELDS - 1) : fieldIdx'(`CLOCK_FIELDS - 1);

    // Binary to two ASCII digits
    always_comb begin
        if (rtcData > 99) begin
            tensChar  = charDash; // Out of range shows "--"
            unitsChar = charDash;
        end else begin
            tensChar  = charZero + 7'(rtcData / 10);
            unitsChar = charZero + 7'(rtcData % 10);
        end
    end

    //////////////////// Sequencer
    // The local port hides the enum literal, hence the scoped commit state
    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (windowStart) begin
                    stateNext = collect; // Sampling starts next cycle
                end
            end
            collect: begin
                if (frameWrap) begin
                    stateNext = abort; // Out of blanking time
                end else if (seqStart && (curField == lastField)) begin
                    stateNext = rtcDisplay_pkg::commit;
                end
            end
            rtcDisplay_pkg::commit: stateNext = idle;
            default: stateNext = idle; // Abort lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= idle;
            curField     <= secs;
            timerLatched <= 1'b0;
            wrEn         <= 1'b0;
            commit       <= 1'b0;
        end else begin
            state  <= stateNext;
            wrEn   <= sampleNow; // Write trails the sample by one cycle
            commit <= (state == rtcDisplay_pkg::commit);
            if ((state == idle) && windowStart) begin
                curField     <= secs;
                timerLatched <= timerOn; // Field count fixed for this window
            end else if (sampleNow && (curField != lastField)) begin
                curField <= fieldIdx'(curField + 4'd1);
            end
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (sampleNow) begin
            wrField <= curField;
            wrTens  <= tensChar;
            wrUnits <= unitsChar;
        end
    end

endmodule

//--- rtl/fieldBank.sv
`include "rtcDisplay_settings.svh"

module fieldBank (
    input  logic                                          clk,
    input  logic                                          rstN,
    input  logic                                          wrEn,
    input  logic                                          commit,
    input  logic                                          timerLatched,
    input  rtcDisplay_pkg::fieldIdx                       wrField,
    input  rtcDisplay_pkg::asciiChar                      wrTens,
    input  rtcDisplay_pkg::asciiChar                      wrUnits,
    output rtcDisplay_pkg::asciiChar [0:2*`NUM_FIELDS-1] dispChars,
    output logic                                          showTimer
);
    import rtcDisplay_pkg::*;

    asciiChar [0:2*`NUM_FIELDS-1] shadow; // Filled during the capture window
    logic [4:0]                   wrSlot;

    assign wrSlot = {wrField, 1'b0}; // Tens slot, units right after

    always_ff @(posedge clk) begin
        if (wrEn) begin
            shadow[wrSlot]         <= wrTens;
            shadow[wrSlot + 5'd1]  <= wrUnits;
        end
    end

    //////////////////// Display copy
    // Whole set moves in one edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dispChars <= {(2 * `NUM_FIELDS){charSpace}};
            showTimer <= 1'b0;
        end else if (commit) begin
            dispChars <= shadow;
            showTimer <= timerLatched; // Timer row only if this set has it
        end
    end

endmodule

//--- render/textRenderer.sv
`include "rtcDisplay_settings.svh"

module textRenderer (
    input  logic                                         clk,
    input  logic                                         rstN,
    input  logic                                         hsyncRaw,
    input  logic                                         vsyncRaw,
    input  logic                                         activeRaw,
    input  logic                                         showTimer,
    input  logic [9:0]                                   pixelX,
    input  logic [9:0]                                   pixelY,
    input  rtcDisplay_pkg::asciiChar [0:2*`NUM_FIELDS-1] dispChars,
    output logic                                         hsync,
    output logic                                         vsync,
    output logic                                         videoOn,
    output logic [11:0]                                  rgb
);
    import rtcDisplay_pkg::*;

    localparam int textW = 8 * `CELL_PIX; // Eight cells per row
    localparam int textH = 4 * `CELL_PIX; // Four rows

    asciiChar [0:31] screen; // Row-major, 4 x 8 cells
    logic [9:0]      relX;
    logic [9:0]      relY;
    logic [1:0]      cellRow;
    logic [2:0]      cellCol;
    logic [2:0]      glyphLine;
    logic [2:0]      glyphCol;
    logic            inText;

    // Stage 1
    logic [7:0] rowBits;
    logic [2:0] bitSel;
    logic       hitS1;
    logic       hsS1;
    logic       vsS1;
    logic       actS1;
    logic       lit;

    //////////////////// Layout
    // Char 2f is the tens of field f, 2f+1 the units
    always_comb begin
        screen = {32{charSpace}};
        screen[0:7] = {dispChars[4], dispChars[5], charColon, // hh:
                       dispChars[2], dispChars[3], charColon, // mm:
                       dispChars[0], dispChars[1]};           // ss
        screen[8:15] = {dispChars[6], dispChars[7], charSlash,
                        dispChars[8], dispChars[9], charSlash,
                        dispChars[10], dispChars[11]}; // dd/mm/yy
        screen[16:17] = {dispChars[12], dispChars[13]}; // Weekday
        screen[19:20] = {dispChars[14], dispChars[15]}; // Week number
        if (showTimer) begin
            screen[24:31] = {dispChars[20], dispChars[21], charColon,
                             dispChars[18], dispChars[19], charColon,
                             dispChars[16], dispChars[17]};
        end
    end

    // Pixel to cell and font coordinates
    assign relX = pixelX - 10'(`TEXT_X0);
    assign relY = pixelY - 10'(`TEXT_Y0);
    assign inText = (pixelX >= 10'(`TEXT_X0)) && (pixelX < 10'(`TEXT_X0 + textW))
                 && (pixelY >= 10'(`TEXT_Y0)) && (pixelY < 10'(`TEXT_Y0 + textH));
    assign cellCol = 3'(relX / `CELL_PIX);
    assign cellRow = 2'(relY / `CELL_PIX);
    assign glyphCol = 3'((relX % `CELL_PIX) / `FONT_SCALE); // Scale by pixel replication
    assign glyphLine = 3'((relY % `CELL_PIX) / `FONT_SCALE);

    //////////////////// Stage 1
    always_ff @(posedge clk) begin
        rowBits <= glyphRow(screen[{cellRow, cellCol}], glyphLine);
        bitSel  <= glyphCol;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hitS1 <= 1'b0;
            hsS1  <= 1'b1;
            vsS1  <= 1'b1;
            actS1 <= 1'b0;
        end else begin
            hitS1 <= inText;
            hsS1  <= hsyncRaw;
            vsS1  <= vsyncRaw;
            actS1 <= activeRaw;
        end
    end

    assign lit = hitS1 && rowBits[3'd7 - bitSel]; // Bit 7 is leftmost

    //////////////////// Stage 2
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            videoOn <= 1'b0;
            rgb     <= `BLANK_COLOR;
        end else begin
            hsync   <= hsS1;
            vsync   <= vsS1;
            videoOn <= actS1;
            if (!actS1) begin
                rgb <= `BLANK_COLOR; // Porches and sync
            end else if (lit) begin
                rgb <= `FG_COLOR;
            end else begin
                rgb <= `BG_COLOR;
            end
        end
    end

endmodule

//--- rtl/rtcDisplay.sv
`include "rtcDisplay_settings.svh"

module rtcDisplay (
    input  logic              clk,
    input  logic              rstN,
    input  logic              seqStart,
    input  logic              timerOn,
    input  logic [`RTC_W-1:0] rtcData,
    output logic              hsync,
    output logic              vsync,
    output logic              videoOn,
    output logic [11:0]       rgb
);
    import rtcDisplay_pkg::*;

    logic [9:0]                   pixelX;
    logic [9:0]                   pixelY;
    logic                         hsyncRaw;
    logic                         vsyncRaw;
    logic                         activeRaw;
    logic                         wrEn;
    logic                         commit;
    logic                         timerLatched;
    fieldIdx                      wrField;
    asciiChar                     wrTens;
    asciiChar                     wrUnits;
    asciiChar [0:2*`NUM_FIELDS-1] dispChars;
    logic                         showTimer;

    //////////////////// Timing
    vgaTiming uTiming (
        .clk      (clk),
        .rstN     (rstN),
        .pixelX   (pixelX),
        .pixelY   (pixelY),
        .hsyncRaw (hsyncRaw),
        .vsyncRaw (vsyncRaw),
        .activeRaw(activeRaw)
    );

    // Producer, writes during vertical blanking
    fieldCapture uCapture (
        .clk         (clk),
        .rstN        (rstN),
        .seqStart    (seqStart),
        .timerOn     (timerOn),
        .rtcData     (rtcData),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .wrEn        (wrEn),
        .commit      (commit),
        .timerLatched(timerLatched),
        .wrField     (wrField),
        .wrTens      (wrTens),
        .wrUnits     (wrUnits)
    );

    fieldBank uBank (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .commit      (commit),
        .timerLatched(timerLatched),
        .wrField     (wrField),
        .wrTens      (wrTens),
        .wrUnits     (wrUnits),
        .dispChars   (dispChars),
        .showTimer   (showTimer)
    );

    // Consumer, two-cycle pixel pipeline
    textRenderer uRender (
        .clk      (clk),
        .rstN     (rstN),
        .hsyncRaw (hsyncRaw),
        .vsyncRaw (vsyncRaw),
        .activeRaw(activeRaw),
        .showTimer(showTimer),
        .pixelX   (pixelX),
        .pixelY   (pixelY),
        .dispChars(dispChars),
        .hsync    (hsync),
        .vsync    (vsync),
        .videoOn  (videoOn),
        .rgb      (rgb)
    );

endmodule

//--- testbench/rtcDisplay_properties.sv
`include "rtcDisplay_settings.svh"

module rtcDisplay_properties (
    input logic        clk,
    input logic        rstN,
    input logic        hsync,
    input logic        videoOn,
    input logic [11:0] rgb,
    input logic        commit,
    input logic [9:0]  pixelY
);

    int lowRun; // Cycles of hsync low so far
    int hsyncFails = 0;
    int blankFails = 0;
    int commitFails = 0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lowRun <= 0;
        end else if (!hsync) begin
            lowRun <= lowRun + 1;
        end else begin
            lowRun <= 0;
        end
    end

    //////////////////// Sync pulse width
    hsyncNotLong: assert property (@(posedge clk) disable iff (!rstN)
        !hsync |-> (lowRun < `H_SYNC))
        else begin
            hsyncFails++;
            $error("hsync low longer than %0d cycles", `H_SYNC);
        end

    hsyncExact: assert property (@(posedge clk) disable iff (!rstN)
        $rose(hsync) |-> (lowRun == `H_SYNC))
        else begin
            hsyncFails++;
            $error("hsync pulse lasted %0d cycles", lowRun);
        end

    // Porches and sync carry no color
    blankOutside: assert property (@(posedge clk) disable iff (!rstN)
        !videoOn |-> (rgb == `BLANK_COLOR))
        else begin
            blankFails++;
            $error("rgb %h while videoOn is low", rgb);
        end

    commitInBlank: assert property (@(posedge clk) disable iff (!rstN)
        commit |-> (pixelY >= 10'(`V_ACTIVE)))
        else begin
            commitFails++;
            $error("commit on visible line %0d", pixelY);
        end

endmodule

bind rtcDisplay rtcDisplay_properties props (
    .clk    (clk),
    .rstN   (rstN),
    .hsync  (hsync),
    .videoOn(videoOn),
    .rgb    (rgb),
    .commit (commit),
    .pixelY (pixelY)
);

//--- testbench/rtcDisplay_tb.sv
`include "rtcDisplay_settings.svh"

module rtcDisplay_tb;
    import rtcDisplay_pkg::*;

    localparam int hTotal = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int vTotal = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int frameCycles = hTotal * vTotal;
    localparam int numFrames = 5;
    localparam int abortFrame = 2; // Window starved of seqStart so it never commits

    logic              clk;
    logic              rstN;
    logic              seqStart;
    logic              timerOn;
    logic [`RTC_W-1:0] rtcData;
    logic              hsync;
    logic              vsync;
    logic              videoOn;
    logic [11:0]       rgb;

    //////////////////// Reference model state
    int                           mx; // Position the DUT counters hold now
    int                           my;
    int                           frameNo;
    bit                           collecting;
    int                           fieldNo;
    int                           fieldCount;
    bit                           winTimer; // timerOn seen at window start
    int                           commitWait; // Edges until the display copy
    asciiChar [0:2*`NUM_FIELDS-1] mShadow;
    asciiChar [0:2*`NUM_FIELDS-1] mDisp;
    bit                           mShow;

    // Two-deep history with index 1 due now
    logic [11:0] expRgb [0:1];
    logic [2:0]  expSync [0:1]; // hsync, vsync, videoOn
    int          expX [0:1];
    int          expY [0:1];

    int colorErrors;
    int syncErrors;
    int charErrors;
    int assertErrors;
    int seedInit;

    rtcDisplay uut (
        .clk     (clk),
        .rstN    (rstN),
        .seqStart(seqStart),
        .timerOn (timerOn),
        .rtcData (rtcData),
        .hsync   (hsync),
        .vsync   (vsync),
        .videoOn (videoOn),
        .rgb     (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////// Model functions
    function automatic asciiChar digitChar(input int value, input bit tens);
        if (value > 99) begin
            return 7'h2D; // Dash
        end
        return tens ? 7'(48 + value / 10) : 7'(48 + value % 10);
    endfunction

    // Three fields with separators as in hh:mm:ss
    function automatic asciiChar tripleChar(input asciiChar [0:2*`NUM_FIELDS-1] disp,
                                            input int fa, input int fb, input int fc,
                                            input asciiChar sep, input int col);
        int f;
        f = (col < 3) ? fa : ((col < 6) ? fb : fc);
        if (col == 2 || col == 5) begin
            return sep;
        end
        return disp[5'(2 * f + ((col % 3 == 1) ? 1 : 0))];
    endfunction

    function automatic asciiChar cellChar(input asciiChar [0:2*`NUM_FIELDS-1] disp,
                                          input bit show, input int row, input int col);
        case (row)
            0: return tripleChar(disp, hours, mins, secs, 7'h3A, col);
            1: return tripleChar(disp, date, month, year, 7'h2F, col);
            2: begin
                if (col < 2) begin
                    return disp[5'(2 * weekday + col)];
                end else if (col == 3 || col == 4) begin
                    return disp[5'(2 * weekNum + col - 3)];
                end
                return 7'h20;
            end
            default: return show ? tripleChar(disp, tHours, tMins, tSecs, 7'h3A, col) : 7'h20;
        endcase
    endfunction

    function automatic logic [11:0] pixelColor(input int x, input int y);
        int        rx;
        int        ry;
        asciiChar  ch;
        logic [7:0] bits;
        if (x >= `H_ACTIVE || y >= `V_ACTIVE) begin
            return `BLANK_COLOR;
        end
        rx = x - `TEXT_X0;
        ry = y - `TEXT_Y0;
        if (rx < 0 || ry < 0 || rx >= 8 * `CELL_PIX || ry >= 4 * `CELL_PIX) begin
            return `BG_COLOR; // Outside the text block
        end
        ch = cellChar(mDisp, mShow, ry / `CELL_PIX, rx / `CELL_PIX);
        bits = glyphRow(ch, 3'((ry % `CELL_PIX) / `FONT_SCALE));
        return bits[3'(7 - (rx % `CELL_PIX) / `FONT_SCALE)] ? `FG_COLOR : `BG_COLOR;
    endfunction

    function automatic logic [2:0] syncBits(input int x, input int y);
        logic hs;
        logic vs;
        logic act;
        hs = !(x >= `H_ACTIVE + `H_FRONT && x < `H_ACTIVE + `H_FRONT + `H_SYNC);
        vs = !(y >= `V_ACTIVE + `V_FRONT && y < `V_ACTIVE + `V_FRONT + `V_SYNC);
        act = (x < `H_ACTIVE) && (y < `V_ACTIVE);
        return {hs, vs, act};
    endfunction

    //////////////////// Compare tasks
    task automatic checkChar(input asciiChar expected, input asciiChar actual,
                             input int row, input int col);
        if (actual !== expected) begin
            charErrors++;
            $display("CHECK FAILED at %0t: cell (%0d,%0d) holds %h, expected %h",
                     $time, row, col, actual, expected);
        end
    endtask

    task automatic checkColor(input logic [11:0] expected, input logic [11:0] actual,
                              input int x, input int y);
        int rx;
        int ry;
        if (actual !== expected) begin
            colorErrors++;
            $display("CHECK FAILED at %0t: rgb at pixel (%0d,%0d) is %h, expected %h",
                     $time, x, y, actual, expected);
            rx = x - `TEXT_X0;
            ry = y - `TEXT_Y0;
            // Tell data faults from drawing faults
            if (rx >= 0 && ry >= 0 && rx < 8 * `CELL_PIX && ry < 4 * `CELL_PIX) begin
                checkChar(cellChar(mDisp, mShow, ry / `CELL_PIX, rx / `CELL_PIX),
                          cellChar(uut.dispChars, uut.showTimer, ry / `CELL_PIX,
                                   rx / `CELL_PIX),
                          ry / `CELL_PIX, rx / `CELL_PIX);
            end
        end
    endtask

    task automatic checkSync(input logic [2:0] expected, input logic [2:0] actual,
                             input int x, input int y);
        if (actual !== expected) begin
            syncErrors++;
            $display("CHECK FAILED at %0t: hsync/vsync/videoOn for (%0d,%0d) is %b, expected %b",
                     $time, x, y, actual, expected);
        end
    endtask

    //////////////////// Stimulus and model step
    task automatic driveInputs();
        if (mx == 0 && my == 0) begin
            // Both timer cases early and random afterwards
            if (frameNo == 0) begin
                timerOn = 1'b1;
            end else if (frameNo == 1) begin
                timerOn = 1'b0;
            end else begin
                timerOn = 1'($urandom % 2);
            end
        end else if (mx == 4 && my == `V_ACTIVE) begin
            timerOn = !timerOn; // Flip after window start so only the latched level counts
        end
        rtcData = 8'($urandom % 121); // Some values above 99
        if (frameNo == abortFrame) begin
            seqStart = (my == vTotal - 1) && (mx >= hTotal - 4) && (($urandom % 4) != 0);
        end else begin
            seqStart = ($urandom % 4) != 0; // 75 percent duty
        end
    endtask

    // Effect of the coming rising edge
    task automatic advanceModel();
        if (commitWait > 0) begin
            commitWait--;
            if (commitWait == 0) begin
                mDisp = mShadow; // Whole set at once
                mShow = winTimer;
            end
        end
        if (collecting) begin
            if (my == 0) begin
                collecting = 1'b0; // Frame wrapped so the sequence is dropped
            end else if (seqStart) begin
                mShadow[5'(2 * fieldNo)] = digitChar(int'(rtcData), 1'b1);
                mShadow[5'(2 * fieldNo + 1)] = digitChar(int'(rtcData), 1'b0);
                if (fieldNo == fieldCount - 1) begin
                    collecting = 1'b0;
                    commitWait = 2; // Write and then the commit pulse
                end else begin
                    fieldNo++;
                end
            end
        end else if (mx == 0 && my == `V_ACTIVE) begin
            collecting = 1'b1;
            fieldNo = 0;
            fieldCount = timerOn ? `NUM_FIELDS : `CLOCK_FIELDS;
            winTimer = timerOn;
        end
        mx++;
        if (mx == hTotal) begin
            mx = 0;
            my++;
            if (my == vTotal) begin
                my = 0;
                frameNo++;
            end
        end
    endtask

    //////////////////// Main sequence
    initial begin
        rstN = 1'b0;
        seqStart = 1'b0;
        timerOn = 1'b0;
        rtcData = '0;
        colorErrors = 0;
        syncErrors = 0;
        charErrors = 0;
        seedInit = $urandom(32'hdd41);
        mx = 0;
        my = 0;
        frameNo = 0;
        collecting = 1'b0;
        commitWait = 0;
        mShow = 1'b0;
        mDisp = {(2 * `NUM_FIELDS){7'h20}}; // Spaces until the first commit
        mShadow = {(2 * `NUM_FIELDS){7'h20}};
        for (int i = 0; i < 2; i++) begin
            expRgb[i] = `BLANK_COLOR; // Reset values of the output stage
            expSync[i] = 3'b110;
            expX[i] = -1;
            expY[i] = -1;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while (frameNo < numFrames) begin
            checkColor(expRgb[1], rgb, expX[1], expY[1]);
            checkSync(expSync[1], {hsync, vsync, videoOn}, expX[1], expY[1]);
            expRgb[1] = expRgb[0];
            expSync[1] = expSync[0];
            expX[1] = expX[0];
            expY[1] = expY[0];
            expRgb[0] = pixelColor(mx, my);
            expSync[0] = syncBits(mx, my);
            expX[0] = mx;
            expY[0] = my;
            driveInputs();
            advanceModel();
            @(negedge clk);
        end
        assertErrors = uut.props.hsyncFails + uut.props.blankFails + uut.props.commitFails;
        $display("Error counts: color %0d, sync %0d, char %0d, assertion %0d",
                 colorErrors, syncErrors, charErrors, assertErrors);
        if (colorErrors + syncErrors + charErrors + assertErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // One spare frame of margin
    initial begin
        #(longint'(numFrames + 1) * frameCycles * 100);
        $display("Watchdog expired before the last frame was checked");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+common
common/rtcDisplay_pkg.sv
rtl/vgaTiming.sv
capture/fieldCapture.sv
rtl/fieldBank.sv
render/textRenderer.sv
rtl/rtcDisplay.sv
testbench/rtcDisplay_properties.sv
testbench/rtcDisplay_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rtcDisplay_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# Output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
